// ==== verilog/tcb_mem_pkg.sv ====
// shared widths, vector types and request/access structs for the TCB byte memory
package tcb_mem_pkg;

  //////////////////////////////////////////////////
  // bus geometry
  //////////////////////////////////////////////////

  // data bus width in bits
  localparam int unsigned tcb_dbw = 32;
  // number of byte lanes per word
  localparam int unsigned tcb_bew = tcb_dbw / 8;

  //////////////////////////////////////////////////
  // vector types
  //////////////////////////////////////////////////

  typedef logic [32-1:0]      tcb_adr_t;   // byte address
  typedef logic [tcb_dbw-1:0] tcb_dat_t;   // data word
  typedef logic [tcb_bew-1:0] tcb_ben_t;   // byte enables, counted from address
  typedef logic [8-1:0]       tcb_byte_t;  // single byte
  typedef logic [2-1:0]       tcb_lane_t;  // lane number inside a word
  typedef logic [tcb_bew-1:0] tcb_rbe_t;   // read enables, lane ordered

  //////////////////////////////////////////////////
  // structs
  //////////////////////////////////////////////////

  // bus request as seen on the port
  typedef struct packed {
    logic     wen;  // 1 = write, 0 = read
    tcb_adr_t adr;
    tcb_ben_t ben;
    tcb_dat_t wdt;
  } tcb_req_t;

  // decoded access, one entry per request byte
  typedef struct packed {
    logic                      vld;
    logic                      wen;
    tcb_ben_t                  ena;  // byte enable per request byte
    tcb_adr_t  [tcb_bew-1:0]   idx;  // memory byte index per request byte
    tcb_lane_t [tcb_bew-1:0]   lne;  // lane used by each request byte
    tcb_dat_t                  wdt;
  } tcb_acc_t;

endpackage

// ==== verilog/tcb_mem_dec.sv ====
// combinational request decoder, turns a bus request into per-byte indices and lanes
`timescale 1ns/1ps

module tcb_mem_dec #(
  // memory size in bytes, power of two
  parameter int unsigned SZ = 256
)(
  input  logic                 vld,
  input  tcb_mem_pkg::tcb_req_t req,
  output tcb_mem_pkg::tcb_acc_t acc
);

  //////////////////////////////////////////////////
  // local signals
  //////////////////////////////////////////////////

  // mask for wrapping the byte index into the array
  localparam tcb_mem_pkg::tcb_adr_t adr_msk = tcb_mem_pkg::tcb_adr_t'(SZ - 1);

  // per-byte address before wrapping
  tcb_mem_pkg::tcb_adr_t [tcb_mem_pkg::tcb_bew-1:0] adr_byt;

  //////////////////////////////////////////////////
  // per-byte address and lane
  //////////////////////////////////////////////////

  // byte b of the request sits at adr+b
  always_comb begin
    for (int unsigned b = 0; b < tcb_mem_pkg::tcb_bew; b++) begin
      adr_byt[b] = req.adr + tcb_mem_pkg::tcb_adr_t'(b);
    end
  end

  //////////////////////////////////////////////////
  // access struct
  //////////////////////////////////////////////////

  always_comb begin
    // strobe and direction straight from the port
    acc.vld = vld;
    acc.wen = req.wen;
    // enables stay in request byte order
    acc.ena = req.ben;
    // write data is still lane ordered
    acc.wdt = req.wdt;
    for (int unsigned b = 0; b < tcb_mem_pkg::tcb_bew; b++) begin
      // modulo SZ addressing, SZ is a power of two
      acc.idx[b] = adr_byt[b] & adr_msk;
      // lane is (adr+b) mod 4
      acc.lne[b] = adr_byt[b][1:0];
    end
  end

endmodule

// ==== verilog/tcb_mem_exe.sv ====
// byte memory array with lane-rotated writes and registered lane-rotated reads
`timescale 1ns/1ps

module tcb_mem_exe #(
  // memory size in bytes, power of two
  parameter int unsigned SZ = 256
)(
  input  logic                  tcb,
  input  logic                  arst_n,
  input  tcb_mem_pkg::tcb_acc_t acc,
  output tcb_mem_pkg::tcb_dat_t rd0,
  output tcb_mem_pkg::tcb_rbe_t rbe0
);

  //////////////////////////////////////////////////
  // local signals
  //////////////////////////////////////////////////

  // array index width
  localparam int unsigned abw = $clog2(SZ);

  // the memory itself, one byte per entry
  tcb_mem_pkg::tcb_byte_t mem [0:SZ-1];

  // write data split into lanes
  tcb_mem_pkg::tcb_byte_t [tcb_mem_pkg::tcb_bew-1:0] wdt_lne;

  // read data register and its next value
  tcb_mem_pkg::tcb_byte_t [tcb_mem_pkg::tcb_bew-1:0] rdt_lne;
  tcb_mem_pkg::tcb_byte_t [tcb_mem_pkg::tcb_bew-1:0] rdt_nxt;
  tcb_mem_pkg::tcb_rbe_t                            rbe_nxt;

  assign wdt_lne = acc.wdt;

  //////////////////////////////////////////////////
  // write access
  //////////////////////////////////////////////////

  // byte b of the request comes from lane lne[b]
  always_ff @(posedge tcb) begin
    if (acc.vld && acc.wen) begin
      for (int unsigned b = 0; b < tcb_mem_pkg::tcb_bew; b++) begin
        if (acc.ena[b]) begin
          mem[acc.idx[b][abw-1:0]] <= wdt_lne[acc.lne[b]];
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // read access
  //////////////////////////////////////////////////

  // unread lanes hold, enabled bytes land in their lanes
  always_comb begin
    rdt_nxt = rdt_lne;
    rbe_nxt = '0;
    if (acc.vld && !acc.wen) begin
      for (int unsigned b = 0; b < tcb_mem_pkg::tcb_bew; b++) begin
        if (acc.ena[b]) begin
          rdt_nxt[acc.lne[b]] = mem[acc.idx[b][abw-1:0]];
          rbe_nxt[acc.lne[b]] = 1'b1;
        end
      end
    end
  end

  // first read data stage
  always_ff @(posedge tcb or negedge arst_n) begin
    if (!arst_n) begin
      rdt_lne <= '0;
      rbe0    <= '0;
    end else begin
      rdt_lne <= rdt_nxt;
      // mask lives one cycle, tells the pipeline which lanes moved
      rbe0    <= rbe_nxt;
    end
  end

  assign rd0 = rdt_lne;

endmodule

// ==== verilog/tcb_mem_rsp.sv ====
// read data delay pipeline, each stage updates only the lanes that were read
`timescale 1ns/1ps

module tcb_mem_rsp #(
  // total read latency in cycles, at least 1
  parameter int unsigned DLY = 2
)(
  input  logic                  tcb,
  input  logic                  arst_n,
  input  tcb_mem_pkg::tcb_dat_t rd0,
  input  tcb_mem_pkg::tcb_rbe_t rbe0,
  output tcb_mem_pkg::tcb_dat_t rdt
);

  generate
  if (DLY == 1) begin : g_dir

    // array read register already gives the full latency
    assign rdt = rd0;

  end else begin : g_pip

    //////////////////////////////////////////////////
    // stage registers, index 0 is the execute stage
    //////////////////////////////////////////////////

    tcb_mem_pkg::tcb_byte_t [tcb_mem_pkg::tcb_bew-1:0] dat [0:DLY-1];
    tcb_mem_pkg::tcb_rbe_t                            rbe [0:DLY-2];

    assign dat[0] = rd0;
    assign rbe[0] = rbe0;

    for (genvar d = 1; d < DLY; d++) begin : g_stg
      always_ff @(posedge tcb or negedge arst_n) begin
        if (!arst_n) begin
          dat[d] <= '0;
        end else begin
          // lane moves only when the mask travelling with it says so
          for (int unsigned l = 0; l < tcb_mem_pkg::tcb_bew; l++) begin
            if (rbe[d-1][l]) begin
              dat[d][l] <= dat[d-1][l];
            end
          end
        end
      end
    end

    // mask registers follow the data up to the last stage
    for (genvar d = 1; d < DLY-1; d++) begin : g_msk
      always_ff @(posedge tcb or negedge arst_n) begin
        if (!arst_n) begin
          rbe[d] <= '0;
        end else begin
          rbe[d] <= rbe[d-1];
        end
      end
    end

    // last stage drives the port
    assign rdt = dat[DLY-1];

  end
  endgenerate

endmodule

// ==== verilog/tcb_mem_top.sv ====
// top level of the TCB byte memory, wires decode, execute and response stages
`timescale 1ns/1ps

module tcb_mem_top #(
  // memory size in bytes, power of two
  parameter int unsigned SZ  = 256,
  // read latency in cycles, at least 1
  parameter int unsigned DLY = 2
)(
  input  logic                  tcb,
  input  logic                  arst_n,
  input  logic                  vld,
  input  tcb_mem_pkg::tcb_req_t req,
  output tcb_mem_pkg::tcb_dat_t rdt
);

  //////////////////////////////////////////////////
  // internal connections
  //////////////////////////////////////////////////

  // decoded access
  tcb_mem_pkg::tcb_acc_t acc;
  // first stage read data and lane mask
  tcb_mem_pkg::tcb_dat_t rd0;
  tcb_mem_pkg::tcb_rbe_t rbe0;

  //////////////////////////////////////////////////
  // stages
  //////////////////////////////////////////////////

  // request to per-byte index and lane
  tcb_mem_dec #(
    .SZ  (SZ)
  ) u_dec (
    .vld (vld),
    .req (req),
    .acc (acc)
  );

  // array write, registered read
  tcb_mem_exe #(
    .SZ     (SZ)
  ) u_exe (
    .tcb    (tcb),
    .arst_n (arst_n),
    .acc    (acc),
    .rd0    (rd0),
    .rbe0   (rbe0)
  );

  // remaining DLY-1 cycles of read latency
  tcb_mem_rsp #(
    .DLY    (DLY)
  ) u_rsp (
    .tcb    (tcb),
    .arst_n (arst_n),
    .rd0    (rd0),
    .rbe0   (rbe0),
    .rdt    (rdt)
  );

endmodule

// ==== sim/tcb_mem_tb.sv ====
// testbench for the TCB byte memory, replays the trace file and checks read data against it
`timescale 1ns/1ps

module tcb_mem_tb;

  //////////////////////////////////////////////////
  // constants
  //////////////////////////////////////////////////

  // DUT configuration
  localparam int unsigned SZ  = 256;
  localparam int unsigned DLY = 2;

  // trace file, relative to the project root
  localparam string trace_file = "sim/tcb_mem_trace.txt";
  // seed for the idle gap generator
  localparam int unsigned seed = 77;
  // longest idle gap between transfers, in cycles
  localparam int unsigned gap_max = 3;
  // clock period in ns
  localparam int clk_per = 4;
  // reset length in cycles
  localparam int unsigned rst_cyc = 8;

  //////////////////////////////////////////////////
  // signals and queues
  //////////////////////////////////////////////////

  logic                  tcb = 1'b0;
  logic                  arst_n;
  logic                  vld;
  tcb_mem_pkg::tcb_req_t req;
  tcb_mem_pkg::tcb_dat_t rdt;

  // rising edge count
  int unsigned cyc = 0;

  // transfers as read from the trace
  tcb_mem_pkg::tcb_req_t trc_req [$];
  tcb_mem_pkg::tcb_dat_t trc_exp [$];
  bit                    trc_b2b [$];
  int unsigned           n_ops = 0;

  // reads in flight, expected word and due cycle
  tcb_mem_pkg::tcb_dat_t pend_dat [$];
  int unsigned           pend_due [$];

  //////////////////////////////////////////////////
  // DUT
  //////////////////////////////////////////////////

  tcb_mem_top #(
    .SZ     (SZ),
    .DLY    (DLY)
  ) u_tcb_mem_top (
    .tcb    (tcb),
    .arst_n (arst_n),
    .vld    (vld),
    .req    (req),
    .rdt    (rdt)
  );

  // free running clock
  always #(clk_per/2) tcb = ~tcb;

  always @(posedge tcb) cyc <= cyc + 1;

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "simulation stopped");
  endtask

  // read data word compare
  task automatic check_rdt(input tcb_mem_pkg::tcb_dat_t exp_v,
                           input tcb_mem_pkg::tcb_dat_t act_v);
    if (act_v !== exp_v) begin
      abort_run($sformatf("error rdt expected %h actual %h", exp_v, act_v));
    end
  endtask

  // parse the whole trace into queues
  task automatic load_trace();
    int                    fd;
    int                    cnt;
    int unsigned           lno;
    string                 line;
    logic [7:0]            op;
    tcb_mem_pkg::tcb_adr_t adr;
    tcb_mem_pkg::tcb_ben_t ben;
    tcb_mem_pkg::tcb_dat_t wdt;
    tcb_mem_pkg::tcb_dat_t rdt_exp;
    tcb_mem_pkg::tcb_req_t r;
    fd = $fopen(trace_file, "r");
    if (fd == 0) begin
      abort_run($sformatf("cannot open trace file %s", trace_file));
    end
    lno = 0;
    while ($fgets(line, fd) != 0) begin
      lno++;
      // skip comments and blank lines
      if (line.len() < 2 || line.getc(0) == "#") continue;
      cnt = $sscanf(line, "%c %h %h %h %h", op, adr, ben, wdt, rdt_exp);
      if (cnt != 5) begin
        abort_run($sformatf("trace line %0d does not hold five fields", lno));
      end
      r.adr = adr;
      r.ben = ben;
      r.wdt = wdt;
      case (op)
        "w", "W": r.wen = 1'b1;
        "r", "R": r.wen = 1'b0;
        default:  abort_run($sformatf("trace line %0d has an unknown operation", lno));
      endcase
      trc_req.push_back(r);
      trc_exp.push_back(rdt_exp);
      // upper case means no idle gap before this transfer
      trc_b2b.push_back(op == "W" || op == "R");
    end
    $fclose(fd);
    n_ops = trc_req.size();
    if (n_ops == 0) begin
      abort_run("trace file holds no transfers");
    end
  endtask

  // one cycle with no request
  task automatic idle_cycle();
    @(posedge tcb);
    #1;
    vld = 1'b0;
  endtask

  // one request, reads also queue their expected word
  task automatic send_transfer(input tcb_mem_pkg::tcb_req_t r,
                               input tcb_mem_pkg::tcb_dat_t rdt_exp);
    @(posedge tcb);
    #1;
    vld = 1'b1;
    req = r;
    if (!r.wen) begin
      pend_dat.push_back(rdt_exp);
      pend_due.push_back(cyc + DLY);
    end
  endtask

  //////////////////////////////////////////////////
  // response checker
  //////////////////////////////////////////////////

  // mid cycle, rdt settled since the last rising edge
  always @(negedge tcb) begin
    if (pend_due.size() != 0) begin
      if (pend_due[0] == cyc) begin
        check_rdt(pend_dat[0], rdt);
        pend_dat.delete(0);
        pend_due.delete(0);
      end
    end
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial begin
    int unsigned gap;
    void'($urandom(seed));
    arst_n = 1'b0;
    vld    = 1'b0;
    req    = '0;
    load_trace();
    repeat (rst_cyc) @(posedge tcb);
    #1;
    arst_n = 1'b1;
    // read data comes out of reset as zero
    @(negedge tcb);
    check_rdt('0, rdt);
    for (int unsigned i = 0; i < n_ops; i++) begin
      gap = trc_b2b[i] ? 0 : $urandom % (gap_max + 1);
      repeat (gap) idle_cycle();
      send_transfer(trc_req[i], trc_exp[i]);
    end
    idle_cycle();
    // let the reads in flight come back
    while (pend_due.size() != 0) @(negedge tcb);
    $display("test passed");
    $finish;
  end

  // watchdog, limit scales with the trace length
  initial begin
    int unsigned lim;
    // trace is parsed in the first time step
    #1;
    lim = n_ops * (gap_max + DLY + 2) + 20;
    repeat (lim) @(posedge tcb);
    abort_run($sformatf("timeout, run did not end within %0d clock cycles", lim));
  end

endmodule

// ==== sim/tcb_mem_trace.txt ====
# op adr ben wdt rdt, all hex; op w or r, upper case W or R issues with no idle gap before it
# rdt is the expected read data for reads and is unused (zero) for writes
# aligned full words
w 00000000 f 11223344 00000000
r 00000000 f 00000000 11223344
w 00000004 f a5a5c3c3 00000000
r 00000004 f 00000000 a5a5c3c3
w 00000010 f deadbeef 00000000
w 00000014 f 01234567 00000000
w 00000018 f 89abcdef 00000000
R 00000010 f 00000000 deadbeef
R 00000014 f 00000000 01234567
R 00000018 f 00000000 89abcdef
# partial writes
w 00000000 5 aabbccdd 00000000
r 00000000 f 00000000 11bb33dd
w 00000004 a 99887766 00000000
r 00000004 f 00000000 99a577c3
# misaligned, lanes rotate
w 00000013 f cafef00d 00000000
r 00000013 f 00000000 cafef00d
r 00000010 f 00000000 caadbeef
r 00000014 f 00000000 01fef00d
w 00000021 f 76543210 00000000
R 00000021 f 00000000 76543210
w 00000020 1 000000aa 00000000
r 00000020 f 00000000 765432aa
r 00000024 1 00000000 76543210
w 00000032 f 0f1e2d3c 00000000
W 00000030 3 00004b6b 00000000
R 00000032 f 00000000 0f1e2d3c
r 00000030 f 00000000 0f1e4b6b
r 00000034 3 00000000 0f1e2d3c
# address wrap at the top of memory
w 000000fe f 13579bdf 00000000
r 000000fe f 00000000 13579bdf
r 00000000 f 00000000 11bb9bdf
r 000000fc c 00000000 13579bdf
r 00000104 f 00000000 99a577c3
w 000001ff 3 e100001e 00000000
R 000000ff 3 00000000 e1a5771e
# partial reads keep the other lanes
r 00000010 1 00000000 e1a577ef
r 00000012 1 00000000 e1ad77ef
r 00000015 2 00000000 e1fe77ef
r 00000019 1 00000000 e1fecdef
r 00000007 1 00000000 99fecdef
# back to back, read after write
w 00000040 f 11111111 00000000
R 00000040 f 00000000 11111111
W 00000040 f 22334455 00000000
R 00000040 f 00000000 22334455
W 00000042 f 66778899 00000000
R 00000040 f 00000000 66774455
R 00000044 3 00000000 66778899
R 00000042 f 00000000 66778899
W 00000041 6 aabbccdd 00000000
R 00000040 f 00000000 aabb4455
R 00000000 f 00000000 11bb9b1e
R 000000fc c 00000000 e1579b1e
r 00000014 f 00000000 01fef00d
r 00000020 f 00000000 765432aa
R 000000fe 5 00000000 7657321e
r 00000104 4 00000000 76a5321e

// ==== list.f ====
verilog/tcb_mem_pkg.sv
verilog/tcb_mem_dec.sv
verilog/tcb_mem_exe.sv
verilog/tcb_mem_rsp.sv
verilog/tcb_mem_top.sv
sim/tcb_mem_tb.sv

// ==== Makefile ====
# Verilator build and run of the TCB byte memory testbench

TOP = tcb_mem_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -f list.f
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only -Wall --timescale 1ns/1ps --top-module tcb_mem_top \
	  verilog/tcb_mem_pkg.sv verilog/tcb_mem_dec.sv verilog/tcb_mem_exe.sv \
	  verilog/tcb_mem_rsp.sv verilog/tcb_mem_top.sv

clean:
	rm -rf obj_dir
